/* logic/recovery_pkg.sv */
// Shared opcodes, constants and packed types for the recovery handler RTL and testbench
package recovery_pkg;

  // Recovery register geometry
  localparam int unsigned RegBytes = 4;
  localparam int unsigned IdxWidth = $clog2(RegBytes);
  localparam int unsigned LenWidth = 16;

  localparam logic [7:0] RecoveryMode = 8'h03;
  localparam logic [7:0] ActivateImage = 8'h0F;
  localparam logic [RegBytes*8-1:0] ProtCapValue = 32'h0001_0032;

  // SMBus CRC-8, seeded with zero
  localparam logic [7:0] PecPoly = 8'h07;

  typedef enum logic [7:0] {
    PROT_CAP        = 8'd34,
    DEVICE_STATUS   = 8'd36,
    RECOVERY_CTRL   = 8'd38,
    RECOVERY_STATUS = 8'd39
  } rec_cmd_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_CMD,
    RX_LEN_LO,
    RX_LEN_HI,
    RX_DATA,
    RX_PEC,
    RX_WAIT_END
  } rx_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_LEN_LO,
    TX_LEN_HI,
    TX_DATA,
    TX_PEC
  } tx_state_e;

  // One parsed command, payload byte 0 in the low bits
  typedef struct packed {
    rec_cmd_e                opcode;
    logic                    is_rd;
    logic [LenWidth-1:0]     len;
    logic [RegBytes*8-1:0]   data;
    logic                    error;
  } rec_cmd_t;

  typedef struct packed {
    logic [LenWidth-1:0]   len;
    logic [RegBytes*8-1:0] data;
  } rec_resp_t;

  // Address byte seen on the bus, RnW in bit 0
  typedef struct packed {
    logic       valid;
    logic [7:0] addr;
  } bus_addr_t;

endpackage

/* logic/recovery_pec.sv */
// CRC-8 accumulator for SMBus PEC, one byte per cycle, shared by receive and transmit paths
module recovery_pec (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       clear_i,
  input  logic       valid_i,
  input  logic [7:0] data_i,
  output logic [7:0] crc_o
);

  logic [7:0] crc_q;
  logic [7:0] base;

  function automatic logic [7:0] fold(input logic [7:0] crc, input logic [7:0] data);
    logic [7:0] c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ({c[6:0], 1'b0} ^ recovery_pkg::PecPoly) : {c[6:0], 1'b0};
    end
    return c;
  endfunction

  // Clear together with valid seeds the CRC with the byte
  assign base = clear_i ? 8'h00 : crc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= 8'h00;
    end else if (valid_i) begin
      crc_q <= fold(base, data_i);
    end else if (clear_i) begin
      crc_q <= 8'h00;
    end
  end

  assign crc_o = crc_q;

endmodule

/* logic/recovery_receiver.sv */
// Parses recovery write frames and read requests from the RX byte stream and checks the PEC
module recovery_receiver (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   rec_en_i,
  input  logic                   rx_valid_i,
  input  logic [7:0]             rx_data_i,
  output logic                   rx_ready_o,
  input  logic                   bus_start_i,
  input  logic                   bus_stop_i,
  input  recovery_pkg::bus_addr_t bus_addr_i,
  output logic                   cmd_valid_o,
  output recovery_pkg::rec_cmd_t cmd_o
);

  recovery_pkg::rx_state_e state_q;
  recovery_pkg::rec_cmd_t  cmd_q;
  logic                    cmd_valid_q;
  logic [recovery_pkg::LenWidth-1:0] cnt_q;
  logic [recovery_pkg::LenWidth-1:0] len_rx;

  logic       wr_addr;
  logic       rd_addr;
  logic       pec_valid;
  logic [7:0] pec_data;
  logic [7:0] pec_crc;

  assign wr_addr = rec_en_i && bus_addr_i.valid && !bus_addr_i.addr[0];
  assign rd_addr = rec_en_i && bus_addr_i.valid && bus_addr_i.addr[0];
  assign len_rx  = {rx_data_i, cmd_q.len[7:0]};

  // Every byte up to the PEC byte is covered, starting from the write address
  always_comb begin
    pec_valid = wr_addr;
    pec_data  = bus_addr_i.addr;
    if (!wr_addr && rx_valid_i) begin
      pec_data = rx_data_i;
      pec_valid = state_q inside {recovery_pkg::RX_CMD, recovery_pkg::RX_LEN_LO,
                                  recovery_pkg::RX_LEN_HI, recovery_pkg::RX_DATA};
    end
  end

  recovery_pec rx_pec (
    .clk_i,
    .arst_n_i,
    .clear_i (wr_addr),
    .valid_i (pec_valid),
    .data_i  (pec_data),
    .crc_o   (pec_crc)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= recovery_pkg::RX_IDLE;
      cmd_q       <= '0;
      cmd_valid_q <= 1'b0;
      cnt_q       <= '0;
    end else begin
      cmd_valid_q <= 1'b0;
      if (!rec_en_i) begin
        state_q <= recovery_pkg::RX_IDLE;
      end else if (wr_addr) begin
        // A write address always opens a fresh frame
        cmd_q   <= '0;
        cnt_q   <= '0;
        state_q <= recovery_pkg::RX_CMD;
      end else begin
        case (state_q)
          recovery_pkg::RX_CMD: begin
            if (bus_start_i || bus_stop_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              cmd_q.opcode <= recovery_pkg::rec_cmd_e'(rx_data_i);
              state_q      <= recovery_pkg::RX_LEN_LO;
            end
          end
          recovery_pkg::RX_LEN_LO: begin
            // Repeated start lands here before the read address
            if (rd_addr) begin
              cmd_q.is_rd <= 1'b1;
              cmd_q.len   <= '0;
              cmd_valid_q <= 1'b1;
              state_q     <= recovery_pkg::RX_IDLE;
            end else if (bus_stop_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              cmd_q.len[7:0] <= rx_data_i;
              state_q        <= recovery_pkg::RX_LEN_HI;
            end
          end
          recovery_pkg::RX_LEN_HI: begin
            if (bus_start_i || bus_stop_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              cmd_q.len[15:8] <= rx_data_i;
              if (len_rx > recovery_pkg::LenWidth'(recovery_pkg::RegBytes)) begin
                cmd_q.error <= 1'b1;
              end
              state_q <= (len_rx == '0) ? recovery_pkg::RX_PEC : recovery_pkg::RX_DATA;
            end
          end
          recovery_pkg::RX_DATA: begin
            if (bus_start_i || bus_stop_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              if (cnt_q < recovery_pkg::LenWidth'(recovery_pkg::RegBytes)) begin
                cmd_q.data[cnt_q[recovery_pkg::IdxWidth-1:0]*8 +: 8] <= rx_data_i;
              end else begin
                cmd_q.error <= 1'b1;
              end
              cnt_q <= cnt_q + 1'b1;
              if (cnt_q == cmd_q.len - 1'b1) begin
                state_q <= recovery_pkg::RX_PEC;
              end
            end
          end
          recovery_pkg::RX_PEC: begin
            if (bus_start_i || bus_stop_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              if (rx_data_i != pec_crc) begin
                cmd_q.error <= 1'b1;
              end
              state_q <= recovery_pkg::RX_WAIT_END;
            end
          end
          recovery_pkg::RX_WAIT_END: begin
            if (bus_stop_i) begin
              cmd_valid_q <= 1'b1;
              state_q     <= recovery_pkg::RX_IDLE;
            end else if (bus_start_i) begin
              state_q <= recovery_pkg::RX_IDLE;
            end else if (rx_valid_i) begin
              // Trailing bytes after the PEC spoil the frame
              cmd_q.error <= 1'b1;
            end
          end
          default: state_q <= recovery_pkg::RX_IDLE;
        endcase
      end
    end
  end

  // Never stalls, bytes outside a frame are dropped
  assign rx_ready_o  = 1'b1;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

  a_cmd_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

/* logic/recovery_executor.sv */
// Executes parsed recovery commands against the recovery register file and builds read responses
module recovery_executor (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [7:0]              dev_status_i,
  output logic                    rec_en_o,
  input  logic                    cmd_valid_i,
  input  recovery_pkg::rec_cmd_t  cmd_i,
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output recovery_pkg::rec_resp_t res_o,
  output logic                    image_activated_o
);

  logic [recovery_pkg::RegBytes*8-1:0] ctrl_q;
  logic [recovery_pkg::RegBytes*8-1:0] status_q;
  logic                    image_activated_q;
  logic                    res_valid_q;
  recovery_pkg::rec_resp_t res_q;
  recovery_pkg::rec_resp_t rd_resp;
  logic                    wr_ok;

  assign rec_en_o = (dev_status_i == recovery_pkg::RecoveryMode);

  // Only full-width, error-free writes reach a register
  assign wr_ok = cmd_valid_i && !cmd_i.is_rd && !cmd_i.error &&
                 (cmd_i.len == recovery_pkg::LenWidth'(recovery_pkg::RegBytes));

  always_comb begin
    rd_resp = '0;
    case (cmd_i.opcode)
      recovery_pkg::PROT_CAP: begin
        rd_resp.len  = recovery_pkg::LenWidth'(recovery_pkg::RegBytes);
        rd_resp.data = recovery_pkg::ProtCapValue;
      end
      recovery_pkg::DEVICE_STATUS: begin
        rd_resp.len       = recovery_pkg::LenWidth'(recovery_pkg::RegBytes);
        rd_resp.data[7:0] = dev_status_i;
      end
      recovery_pkg::RECOVERY_CTRL: begin
        rd_resp.len  = recovery_pkg::LenWidth'(recovery_pkg::RegBytes);
        rd_resp.data = ctrl_q;
      end
      recovery_pkg::RECOVERY_STATUS: begin
        rd_resp.len  = recovery_pkg::LenWidth'(recovery_pkg::RegBytes);
        rd_resp.data = status_q;
      end
      default: rd_resp = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q            <= '0;
      status_q          <= '0;
      image_activated_q <= 1'b0;
      res_valid_q       <= 1'b0;
    end else begin
      if (wr_ok && cmd_i.opcode == recovery_pkg::RECOVERY_CTRL) begin
        ctrl_q <= cmd_i.data;
        // Byte 2 is the activation request, the flag is sticky
        if (cmd_i.data[23:16] == recovery_pkg::ActivateImage) begin
          image_activated_q <= 1'b1;
        end
      end
      if (wr_ok && cmd_i.opcode == recovery_pkg::RECOVERY_STATUS) begin
        status_q <= cmd_i.data;
      end
      if (!rec_en_o) begin
        res_valid_q <= 1'b0;
      end else if (cmd_valid_i && cmd_i.is_rd) begin
        res_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_i.is_rd) begin
      res_q <= rd_resp;
    end
  end

  assign res_valid_o       = res_valid_q;
  assign res_o             = res_q;
  assign image_activated_o = image_activated_q;

  a_one_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i && cmd_i.is_rd |-> !res_valid_o);

endmodule

/* logic/recovery_transmitter.sv */
// Serializes read responses onto the TX byte stream with a trailing PEC and honours host aborts
module recovery_transmitter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    rec_en_i,
  input  recovery_pkg::bus_addr_t bus_addr_i,
  input  logic                    bus_stop_i,
  input  logic                    host_nack_i,
  input  logic                    res_valid_i,
  output logic                    res_ready_o,
  input  recovery_pkg::rec_resp_t res_i,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output logic [7:0]              tx_data_o
);

  recovery_pkg::tx_state_e           state_q;
  recovery_pkg::rec_resp_t           res_q;
  logic [recovery_pkg::LenWidth-1:0] cnt_q;

  logic       rd_addr;
  logic       tx_fire;
  logic       abort;
  logic       pec_valid;
  logic [7:0] pec_data;
  logic [7:0] pec_crc;

  assign rd_addr     = bus_addr_i.valid && bus_addr_i.addr[0];
  assign tx_valid_o  = (state_q != recovery_pkg::TX_IDLE);
  assign tx_fire     = tx_valid_o && tx_ready_i;
  assign abort       = (host_nack_i || bus_stop_i) && tx_valid_o;
  assign res_ready_o = rec_en_i && (state_q == recovery_pkg::TX_IDLE);

  always_comb begin
    case (state_q)
      recovery_pkg::TX_LEN_LO: tx_data_o = res_q.len[7:0];
      recovery_pkg::TX_LEN_HI: tx_data_o = res_q.len[15:8];
      recovery_pkg::TX_DATA:   tx_data_o = res_q.data[7:0];
      recovery_pkg::TX_PEC:    tx_data_o = pec_crc;
      default:                 tx_data_o = 8'h00;
    endcase
  end

  // Seeded by the read address, then every accepted byte but the PEC itself
  assign pec_valid = rd_addr || (tx_fire && state_q != recovery_pkg::TX_PEC);
  assign pec_data  = rd_addr ? bus_addr_i.addr : tx_data_o;

  recovery_pec tx_pec (
    .clk_i,
    .arst_n_i,
    .clear_i (rd_addr),
    .valid_i (pec_valid),
    .data_i  (pec_data),
    .crc_o   (pec_crc)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= recovery_pkg::TX_IDLE;
      cnt_q   <= '0;
    end else if (!rec_en_i || abort) begin
      state_q <= recovery_pkg::TX_IDLE;
    end else begin
      case (state_q)
        recovery_pkg::TX_IDLE: begin
          if (res_valid_i) begin
            cnt_q   <= '0;
            state_q <= recovery_pkg::TX_LEN_LO;
          end
        end
        recovery_pkg::TX_LEN_LO: begin
          if (tx_ready_i) state_q <= recovery_pkg::TX_LEN_HI;
        end
        recovery_pkg::TX_LEN_HI: begin
          if (tx_ready_i) begin
            state_q <= (res_q.len == '0) ? recovery_pkg::TX_PEC : recovery_pkg::TX_DATA;
          end
        end
        recovery_pkg::TX_DATA: begin
          if (tx_ready_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == res_q.len - 1'b1) state_q <= recovery_pkg::TX_PEC;
          end
        end
        recovery_pkg::TX_PEC: begin
          if (tx_ready_i) state_q <= recovery_pkg::TX_IDLE;
        end
        default: state_q <= recovery_pkg::TX_IDLE;
      endcase
    end
  end

  // Payload shifts down so the next data byte is always in the low bits
  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_ready_o) begin
      res_q <= res_i;
    end else if (tx_fire && state_q == recovery_pkg::TX_DATA) begin
      res_q.data <= res_q.data >> 8;
    end
  end

  a_tx_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tx_valid_o && !tx_ready_i |=> !tx_valid_o || $stable(tx_data_o));

endmodule

/* logic/recovery_handler.sv */
// Top level of the I3C recovery packet handler joining receiver, executor and transmitter
module recovery_handler (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [7:0]              dev_status_i,
  input  logic                    rx_valid_i,
  input  logic [7:0]              rx_data_i,
  output logic                    rx_ready_o,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output logic [7:0]              tx_data_o,
  input  logic                    bus_start_i,
  input  logic                    bus_stop_i,
  input  recovery_pkg::bus_addr_t bus_addr_i,
  input  logic                    host_nack_i,
  output logic                    image_activated_o
);

  logic                    rec_en;
  logic                    cmd_valid;
  recovery_pkg::rec_cmd_t  cmd;
  logic                    res_valid;
  logic                    res_ready;
  recovery_pkg::rec_resp_t res;

  recovery_receiver u_receiver (
    .clk_i,
    .arst_n_i,
    .rec_en_i    (rec_en),
    .rx_valid_i,
    .rx_data_i,
    .rx_ready_o,
    .bus_start_i,
    .bus_stop_i,
    .bus_addr_i,
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  recovery_executor u_executor (
    .clk_i,
    .arst_n_i,
    .dev_status_i,
    .rec_en_o    (rec_en),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_o       (res),
    .image_activated_o
  );

  recovery_transmitter u_transmitter (
    .clk_i,
    .arst_n_i,
    .rec_en_i    (rec_en),
    .bus_addr_i,
    .bus_stop_i,
    .host_nack_i,
    .res_valid_i (res_valid),
    .res_ready_o (res_ready),
    .res_i       (res),
    .tx_valid_o,
    .tx_ready_i,
    .tx_data_o
  );

endmodule

/* test/tb_recovery_handler.sv */
// Testbench for the recovery handler, run as top module tb_recovery_handler with the RTL from tb.f
module tb_recovery_handler;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 40;
  localparam int NumFrames = 10;
  localparam logic [7:0] WrAddr = 8'h42;
  localparam logic [7:0] RdAddr = 8'h43;

  logic                    clk_i = 1'b0;
  logic                    arst_n_i;
  logic [7:0]              dev_status_i;
  logic                    rx_valid_i;
  logic [7:0]              rx_data_i;
  logic                    rx_ready_o;
  logic                    tx_valid_o;
  logic                    tx_ready_i;
  logic [7:0]              tx_data_o;
  logic                    bus_start_i;
  logic                    bus_stop_i;
  recovery_pkg::bus_addr_t bus_addr_i;
  logic                    host_nack_i;
  logic                    image_activated_o;

  logic [7:0] tx_bytes[$];
  bit         stall_en = 1'b0;
  integer     seed = 32'h46f22d54;

  recovery_handler uut (
    .clk_i,
    .arst_n_i,
    .dev_status_i,
    .rx_valid_i,
    .rx_data_i,
    .rx_ready_o,
    .tx_valid_o,
    .tx_ready_i,
    .tx_data_o,
    .bus_start_i,
    .bus_stop_i,
    .bus_addr_i,
    .host_nack_i,
    .image_activated_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, got);
    stop_with_failure();
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else report_mismatch(name, exp, got);
  endtask

  task automatic report_problem(input string what);
    $display("At %0t ns: %s", $time, what);
    stop_with_failure();
  endtask

  // Bit-serial SMBus CRC-8, MSB first
  function automatic logic [7:0] pec_step(input logic [7:0] crc, input logic [7:0] b);
    logic fb;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[7] ^ b[i];
      crc = {crc[6:0], 1'b0} ^ (fb ? recovery_pkg::PecPoly : 8'h00);
    end
    return crc;
  endfunction

  task automatic send_address(input logic [7:0] addr);
    bus_start_i = 1'b1;
    @(negedge clk_i);
    bus_start_i      = 1'b0;
    bus_addr_i.valid = 1'b1;
    bus_addr_i.addr  = addr;
    @(negedge clk_i);
    bus_addr_i = '0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    @(negedge clk_i);
    rx_valid_i = 1'b0;
  endtask

  // One idle cycle follows the stop
  task automatic pulse_stop();
    bus_stop_i = 1'b1;
    @(negedge clk_i);
    bus_stop_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic write_reg(input logic [7:0] cmd, input logic [31:0] data, input bit bad_pec);
    logic [7:0] frame[$];
    logic [7:0] crc;
    frame.push_back(cmd);
    frame.push_back(8'h04);
    frame.push_back(8'h00);
    for (int i = 0; i < 4; i++) begin
      frame.push_back(data[i*8 +: 8]);
    end
    crc = pec_step(8'h00, WrAddr);
    foreach (frame[i]) crc = pec_step(crc, frame[i]);
    frame.push_back(bad_pec ? ~crc : crc);
    send_address(WrAddr);
    foreach (frame[i]) send_byte(frame[i]);
    pulse_stop();
  endtask

  task automatic request_read(input logic [7:0] cmd);
    tx_bytes.delete();
    send_address(WrAddr);
    send_byte(cmd);
    // Repeated start with the read address
    send_address(RdAddr);
  endtask

  // Response ends when tx_valid_o drops after the PEC
  task automatic wait_response();
    while (!tx_valid_o) @(negedge clk_i);
    while (tx_valid_o) @(negedge clk_i);
  endtask

  task automatic read_reg(input logic [7:0] cmd, input logic [31:0] data);
    logic [7:0] exp[$];
    logic [7:0] crc;
    request_read(cmd);
    wait_response();
    pulse_stop();
    exp.push_back(8'h04);
    exp.push_back(8'h00);
    for (int i = 0; i < 4; i++) begin
      exp.push_back(data[i*8 +: 8]);
    end
    crc = pec_step(8'h00, RdAddr);
    foreach (exp[i]) crc = pec_step(crc, exp[i]);
    exp.push_back(crc);
    assert (tx_bytes.size() == exp.size()) else
      report_problem($sformatf("response has %0d bytes instead of %0d", tx_bytes.size(),
                               exp.size()));
    foreach (exp[i]) expect_equal($sformatf("tx_data_o byte %0d", i), exp[i], tx_bytes[i]);
  endtask

  always @(negedge clk_i) begin
    tx_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  always @(posedge clk_i) begin
    if (arst_n_i && tx_valid_o && tx_ready_i) begin
      tx_bytes.push_back(tx_data_o);
    end
  end

  a_rx_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i) rx_ready_o)
    else report_mismatch("rx_ready_o", 1, $sampled(rx_ready_o));

  a_tx_off: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dev_status_i != recovery_pkg::RecoveryMode |-> !tx_valid_o)
    else report_mismatch("tx_valid_o", 0, $sampled(tx_valid_o));

  // No abort is driven, so a stalled byte must stay offered
  a_tx_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tx_valid_o && !tx_ready_i |=> tx_valid_o)
    else report_problem("tx_valid_o dropped before the byte was accepted");

  initial begin
    #(NumFrames * 200 * ClkPeriod);
    report_problem("watchdog expired before the tests finished");
  end

  initial begin
    arst_n_i     = 1'b0;
    dev_status_i = recovery_pkg::RecoveryMode;
    rx_valid_i   = 1'b0;
    rx_data_i    = 8'h00;
    tx_ready_i   = 1'b1;
    bus_start_i  = 1'b0;
    bus_stop_i   = 1'b0;
    bus_addr_i   = '0;
    host_nack_i  = 1'b0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    expect_equal("tx_valid_o", 0, tx_valid_o);
    expect_equal("image_activated_o", 0, image_activated_o);
    expect_equal("rx_ready_o", 1, rx_ready_o);

    write_reg(recovery_pkg::RECOVERY_CTRL, 32'h1122_3344, 1'b0);
    read_reg(recovery_pkg::RECOVERY_CTRL, 32'h1122_3344);

    // Corrupted PEC leaves the register alone
    write_reg(recovery_pkg::RECOVERY_CTRL, 32'hAABB_CCDD, 1'b1);
    read_reg(recovery_pkg::RECOVERY_CTRL, 32'h1122_3344);

    stall_en = 1'b1;
    read_reg(recovery_pkg::PROT_CAP, recovery_pkg::ProtCapValue);
    read_reg(recovery_pkg::DEVICE_STATUS, {24'h0, recovery_pkg::RecoveryMode});

    expect_equal("image_activated_o", 0, image_activated_o);
    write_reg(recovery_pkg::RECOVERY_CTRL, 32'h000F_0102, 1'b0);
    expect_equal("image_activated_o", 1, image_activated_o);

    // Recovery mode off, the whole exchange is ignored
    dev_status_i = 8'h01;
    write_reg(recovery_pkg::RECOVERY_CTRL, 32'h5566_7788, 1'b0);
    request_read(recovery_pkg::RECOVERY_CTRL);
    repeat (20) @(negedge clk_i);
    pulse_stop();
    expect_equal("TX byte count", 0, tx_bytes.size());
    dev_status_i = recovery_pkg::RecoveryMode;
    read_reg(recovery_pkg::RECOVERY_CTRL, 32'h000F_0102);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* tb.f */
logic/recovery_pkg.sv
logic/recovery_pec.sv
logic/recovery_receiver.sv
logic/recovery_executor.sv
logic/recovery_transmitter.sv
logic/recovery_handler.sv
test/tb_recovery_handler.sv

/* Bender.yml */
package:
  name: recovery_handler

sources:
  - logic/recovery_pkg.sv
  - logic/recovery_pec.sv
  - logic/recovery_receiver.sv
  - logic/recovery_executor.sv
  - logic/recovery_transmitter.sv
  - logic/recovery_handler.sv
  - target: test
    files:
      - test/tb_recovery_handler.sv
